/* include/rvx_defines.svh */
`ifndef RVX_DEFINES_SVH
`define RVX_DEFINES_SVH

`define XLEN        64
`define NREGS       32
`define RESET_PC    64'h0000_0000_8000_0000

// base opcodes handled by the slice
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011

`endif

/* hdl/rvx_pkg.sv */
`include "rvx_defines.svh"

package rvx_pkg;

    typedef logic [`XLEN-1:0] rvx_xword_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rvx_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rvx_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } rvx_s_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rvx_b_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rvx_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rvx_j_t;

    typedef union packed {
        rvx_r_t r;
        rvx_i_t i;
        rvx_s_t s;
        rvx_b_t b;
        rvx_u_t u;
        rvx_j_t j;
    } rvx_instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } rvx_alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } rvx_br_e;

    typedef struct packed {
        rvx_alu_op_e alu_op;
        logic        sel_a;     // 1 selects pc
        logic        sel_b;     // 1 selects imm
        logic        write_rd;
        logic        jal;
        logic        jalr;
        rvx_br_e     br;
        logic        illegal;
    } rvx_ctrl_t;

endpackage

/* hdl/id_ex_if.sv */
`timescale 1ns/1ps

interface id_ex_if import rvx_pkg::*; (
    input logic clk,
    input logic reset_i
);

    logic       valid;
    rvx_ctrl_t  ctrl;
    rvx_xword_t pc;
    rvx_xword_t imm;
    rvx_xword_t rs1_val;
    rvx_xword_t rs2_val;
    logic [4:0] rd;

    modport dec (output valid, ctrl, pc, imm, rs1_val, rs2_val, rd);

    modport reg_in (input valid, ctrl, pc, imm, rs1_val, rs2_val, rd);

    modport reg_out (output valid, ctrl, pc, imm, rs1_val, rs2_val, rd);

    modport ex (input clk, reset_i, valid, ctrl, pc, imm, rs1_val, rs2_val, rd);

endinterface

/* hdl/rvx_decoder.sv */
`timescale 1ns/1ps
`include "rvx_defines.svh"

module rvx_decoder import rvx_pkg::*; (
    input  rvx_instr_u instr_i,
    output rvx_ctrl_t  ctrl_o,
    output rvx_xword_t imm_o,
    output logic [4:0] rs1_o,
    output logic [4:0] rs2_o,
    output logic [4:0] rd_o
);

    rvx_xword_t imm_i_w;
    rvx_xword_t imm_u_w;
    rvx_xword_t imm_b_w;
    rvx_xword_t imm_j_w;
    logic       wr_req;

    function automatic rvx_alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt,
                                                   input logic is_reg);
        case (f3)
            3'b000:  return (alt && is_reg) ? ALU_SUB : ALU_ADD; // no subi
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic rvx_br_e br_from_funct(input logic [2:0] f3);
        case (f3)
            3'b000:  return BR_EQ;
            3'b001:  return BR_NE;
            3'b100:  return BR_LT;
            3'b101:  return BR_GE;
            3'b110:  return BR_LTU;
            3'b111:  return BR_GEU;
            default: return BR_NONE; // reserved and never taken
        endcase
    endfunction

    assign rs1_o = instr_i.r.rs1;
    assign rs2_o = instr_i.r.rs2;
    assign rd_o  = instr_i.r.rd;

    assign imm_i_w = {{(`XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_u_w = {{(`XLEN-32){instr_i.u.imm[19]}}, instr_i.u.imm, 12'b0};
    assign imm_b_w = {{(`XLEN-13){instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                      instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
    assign imm_j_w = {{(`XLEN-21){instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                      instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};

    always_comb begin
        ctrl_o.alu_op  = ALU_ADD;
        ctrl_o.sel_a   = 1'b0;
        ctrl_o.sel_b   = 1'b0;
        ctrl_o.jal     = 1'b0;
        ctrl_o.jalr    = 1'b0;
        ctrl_o.br      = BR_NONE;
        ctrl_o.illegal = 1'b0;
        imm_o          = '0;
        wr_req         = 1'b0;
        case (instr_i.r.opcode)
            `OPC_OP: begin
                ctrl_o.alu_op = alu_from_funct(instr_i.r.funct3, instr_i.r.funct7[5], 1'b1);
                wr_req        = 1'b1;
            end
            `OPC_OP_IMM: begin
                ctrl_o.alu_op = alu_from_funct(instr_i.i.funct3, instr_i.r.funct7[5], 1'b0);
                ctrl_o.sel_b  = 1'b1;
                imm_o         = imm_i_w;
                wr_req        = 1'b1;
            end
            `OPC_LUI: begin
                ctrl_o.alu_op = ALU_PASS_B;
                ctrl_o.sel_b  = 1'b1;
                imm_o         = imm_u_w;
                wr_req        = 1'b1;
            end
            `OPC_AUIPC: begin
                ctrl_o.sel_a = 1'b1;
                ctrl_o.sel_b = 1'b1;
                imm_o        = imm_u_w;
                wr_req       = 1'b1;
            end
            `OPC_JAL: begin
                ctrl_o.jal = 1'b1;
                imm_o      = imm_j_w;
                wr_req     = 1'b1; // link value
            end
            `OPC_JALR: begin
                ctrl_o.jalr = 1'b1;
                imm_o       = imm_i_w;
                wr_req      = 1'b1;
            end
            `OPC_BRANCH: begin
                ctrl_o.br = br_from_funct(instr_i.b.funct3);
                imm_o     = imm_b_w;
            end
            default: ctrl_o.illegal = 1'b1;
        endcase
        ctrl_o.write_rd = wr_req && (rd_o != 5'd0); // x0 writes dropped here
    end

endmodule

/* hdl/rvx_regfile.sv */
`timescale 1ns/1ps
`include "rvx_defines.svh"

module rvx_regfile import rvx_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic [4:0] rs1_i,
    input  logic [4:0] rs2_i,
    output rvx_xword_t rs1_val_o,
    output rvx_xword_t rs2_val_o,
    input  logic       we_i,
    input  logic [4:0] wa_i,
    input  rvx_xword_t wd_i
);

    rvx_xword_t regs [`NREGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int k = 0; k < `NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (we_i) begin
            regs[wa_i] <= wd_i;
        end
    end

    // write-first, so a result retiring now feeds the instruction in decode
    assign rs1_val_o = (rs1_i == 5'd0)               ? '0   :
                       (we_i && (wa_i == rs1_i))     ? wd_i : regs[rs1_i];
    assign rs2_val_o = (rs2_i == 5'd0)               ? '0   :
                       (we_i && (wa_i == rs2_i))     ? wd_i : regs[rs2_i];

    a_no_x0_write: assert property (@(posedge clk) disable iff (reset_i) we_i |-> wa_i != 5'd0)
        else $error("register file write to x0");

endmodule

/* hdl/rvx_id_ex.sv */
`timescale 1ns/1ps

module rvx_id_ex (
    input logic     clk,
    input logic     reset_i,
    input logic     hold_i,
    input logic     flush_i,
    input logic     load_i,
    id_ex_if.reg_in  d,
    id_ex_if.reg_out q
);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            q.valid <= 1'b0; // drops whatever decode offered
        end else if (!hold_i) begin
            q.valid <= load_i && d.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            q.ctrl    <= d.ctrl;
            q.pc      <= d.pc;
            q.imm     <= d.imm;
            q.rs1_val <= d.rs1_val;
            q.rs2_val <= d.rs2_val;
            q.rd      <= d.rd;
        end
    end

    // hold only with a stalled result, flush only with a consumed one
    a_hold_flush_excl: assert property (@(posedge clk) disable iff (reset_i)
                                        !(hold_i && flush_i))
        else $error("id/ex hold and flush both asserted");

endmodule

/* hdl/rvx_execute.sv */
`timescale 1ns/1ps
`include "rvx_defines.svh"

module rvx_execute import rvx_pkg::*; (
    id_ex_if.ex        e,
    input  logic       res_ready_i,
    output logic       res_valid_o,
    output rvx_xword_t res_pc_o,
    output logic [4:0] res_rd_o,
    output logic       res_we_o,
    output rvx_xword_t res_value_o,
    output logic       res_illegal_o,
    output logic       redir_valid_o,
    output rvx_xword_t redir_pc_o,
    output logic       fire_o
);

    rvx_xword_t op_a;
    rvx_xword_t op_b;
    rvx_xword_t alu_res;
    rvx_xword_t pc_plus4;
    rvx_xword_t target;
    logic [$clog2(`XLEN)-1:0] shamt;
    logic       taken;

    assign op_a  = e.ctrl.sel_a ? e.pc  : e.rs1_val;
    assign op_b  = e.ctrl.sel_b ? e.imm : e.rs2_val;
    assign shamt = op_b[$clog2(`XLEN)-1:0];

    always_comb begin
        case (e.ctrl.alu_op)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b; // lui
            default:    alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (e.ctrl.br)
            BR_EQ:   taken = e.rs1_val == e.rs2_val;
            BR_NE:   taken = e.rs1_val != e.rs2_val;
            BR_LT:   taken = $signed(e.rs1_val) < $signed(e.rs2_val);
            BR_GE:   taken = $signed(e.rs1_val) >= $signed(e.rs2_val);
            BR_LTU:  taken = e.rs1_val < e.rs2_val;
            BR_GEU:  taken = e.rs1_val >= e.rs2_val;
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = e.pc + `XLEN'd4;
    assign target   = e.ctrl.jalr ? ((e.rs1_val + e.imm) & ~`XLEN'd1) : e.pc + e.imm;

    assign fire_o        = e.valid && res_ready_i;
    assign res_valid_o   = e.valid;
    assign res_pc_o      = e.pc;
    assign res_rd_o      = e.rd;
    assign res_we_o      = e.ctrl.write_rd;
    assign res_value_o   = (e.ctrl.jal || e.ctrl.jalr) ? pc_plus4 : alu_res; // link
    assign res_illegal_o = e.ctrl.illegal;

    assign redir_valid_o = fire_o && (e.ctrl.jal || e.ctrl.jalr || taken)
                           && (target != pc_plus4);
    assign redir_pc_o    = target;

    // relies on id/ex holding its payload while the result is stalled
    a_stall_stable: assert property (@(posedge e.clk) disable iff (e.reset_i)
        res_valid_o && !res_ready_i |=> res_valid_o
            && $stable({res_pc_o, res_rd_o, res_we_o, res_value_o, res_illegal_o}))
        else $error("result changed while stalled");

endmodule

/* hdl/rvx_core_slice.sv */
`timescale 1ns/1ps

module rvx_core_slice import rvx_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  rvx_xword_t  in_pc_i,
    input  logic [31:0] in_instr_i,
    output logic        res_valid_o,
    input  logic        res_ready_i,
    output rvx_xword_t  res_pc_o,
    output logic [4:0]  res_rd_o,
    output logic        res_we_o,
    output rvx_xword_t  res_value_o,
    output logic        res_illegal_o,
    output logic        redir_valid_o,
    output rvx_xword_t  redir_pc_o
);

    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    logic       fire;
    logic       hold;
    logic       accept;
    logic       rf_we;

    id_ex_if dec_bus (.clk(clk), .reset_i(reset_i));
    id_ex_if ex_bus  (.clk(clk), .reset_i(reset_i));

    assign dec_bus.valid = in_valid_i;
    assign dec_bus.pc    = in_pc_i;

    rvx_decoder u_decoder (
        .instr_i (in_instr_i),
        .ctrl_o  (dec_bus.ctrl),
        .imm_o   (dec_bus.imm),
        .rs1_o   (rs1_addr),
        .rs2_o   (rs2_addr),
        .rd_o    (dec_bus.rd)
    );

    rvx_regfile u_regfile (
        .clk       (clk),
        .reset_i   (reset_i),
        .rs1_i     (rs1_addr),
        .rs2_i     (rs2_addr),
        .rs1_val_o (dec_bus.rs1_val),
        .rs2_val_o (dec_bus.rs2_val),
        .we_i      (rf_we),
        .wa_i      (res_rd_o),
        .wd_i      (res_value_o)
    );

    assign in_ready_o = !ex_bus.valid || fire; // stage empty or draining
    assign hold       = !in_ready_o;
    assign accept     = in_valid_i && in_ready_o;
    assign rf_we      = fire && res_we_o;  // writeback on consume

    rvx_id_ex u_id_ex (
        .clk     (clk),
        .reset_i (reset_i),
        .hold_i  (hold),
        .flush_i (redir_valid_o),
        .load_i  (accept),
        .d       (dec_bus.reg_in),
        .q       (ex_bus.reg_out)
    );

    rvx_execute u_execute (
        .e             (ex_bus.ex),
        .res_ready_i   (res_ready_i),
        .res_valid_o   (res_valid_o),
        .res_pc_o      (res_pc_o),
        .res_rd_o      (res_rd_o),
        .res_we_o      (res_we_o),
        .res_value_o   (res_value_o),
        .res_illegal_o (res_illegal_o),
        .redir_valid_o (redir_valid_o),
        .redir_pc_o    (redir_pc_o),
        .fire_o        (fire)
    );

endmodule

/* bench/tb_rvx_slice.sv */
`timescale 1ns/1ps
`include "rvx_defines.svh"

module tb_rvx_slice import rvx_pkg::*; ();

    localparam int NUM_INSTR  = 600;
    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT_NS = NUM_INSTR * 4 * CLK_PERIOD;

    logic        clk;
    logic        reset_i;
    logic        in_valid_i;
    logic        in_ready_o;
    rvx_xword_t  in_pc_i;
    logic [31:0] in_instr_i;
    logic        res_valid_o;
    logic        res_ready_i;
    rvx_xword_t  res_pc_o;
    logic [4:0]  res_rd_o;
    logic        res_we_o;
    rvx_xword_t  res_value_o;
    logic        res_illegal_o;
    logic        redir_valid_o;
    rvx_xword_t  redir_pc_o;

    integer      seed;
    logic        ev_accept;
    logic        ev_fire;
    logic        ev_redir;
    rvx_xword_t  ev_redir_pc;
    logic [31:0] ev_instr;
    logic [31:0] instr_q [$];     // accepted but not yet consumed
    rvx_xword_t  mregs [32];
    rvx_xword_t  model_pc;
    logic        exp_valid;
    logic        exp_we;
    logic        exp_x0;
    logic        exp_illegal;
    logic        exp_redir;
    logic [4:0]  exp_rd;
    rvx_xword_t  exp_value;
    rvx_xword_t  exp_target;
    rvx_xword_t  exp_next;
    logic        drop;
    rvx_xword_t  gen_pc;
    logic [31:0] cur_instr;
    logic        need_new;
    int          err_value;
    int          err_proto;
    int          err_cover;
    int          n_results;
    int          n_redir;
    int          n_illegal;
    int          n_x0;
    int          n_stall;

    rvx_core_slice dut0 (.*);

    function automatic rvx_xword_t alu_result(input logic [2:0] f3, input logic alt,
                                              input rvx_xword_t a, input rvx_xword_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return {63'd0, $signed(a) < $signed(b)};
            3'd3: return {63'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[5:0];
                return a >> b[5:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input rvx_xword_t a,
                                          input rvx_xword_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // RV64I rules on the model registers for the instruction at model_pc
    task automatic predict(input logic [31:0] ins);
        rvx_xword_t a;
        rvx_xword_t b;
        rvx_xword_t immi;
        rvx_xword_t immu;
        rvx_xword_t pc4;
        logic       wr;
        logic       jump;
        logic       take;
        a    = mregs[ins[19:15]];
        b    = mregs[ins[24:20]];
        immi = {{52{ins[31]}}, ins[31:20]};
        immu = {{32{ins[31]}}, ins[31:12], 12'h000};
        pc4  = model_pc + 64'd4;
        wr   = 1'b1;
        jump = 1'b0;
        take = 1'b0;
        exp_illegal = 1'b0;
        exp_value   = '0;
        exp_target  = pc4;
        exp_rd      = ins[11:7];
        case (ins[6:0])
            `OPC_OP:     exp_value = alu_result(ins[14:12], ins[30], a, b);
            `OPC_OP_IMM: exp_value = alu_result(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, immi);
            `OPC_LUI:    exp_value = immu;
            `OPC_AUIPC:  exp_value = model_pc + immu;
            `OPC_JAL: begin
                jump       = 1'b1;
                exp_value  = pc4;
                exp_target = model_pc + {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            `OPC_JALR: begin
                jump       = 1'b1;
                exp_value  = pc4;
                exp_target = (a + immi) & ~64'd1;
            end
            `OPC_BRANCH: begin
                wr         = 1'b0;
                take       = branch_taken(ins[14:12], a, b);
                exp_target = model_pc + {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: begin
                wr          = 1'b0;
                exp_illegal = 1'b1;
            end
        endcase
        exp_we    = wr && ins[11:7] != 5'd0;
        exp_x0    = wr && ins[11:7] == 5'd0;
        exp_redir = (jump || take) && exp_target != pc4;
        exp_next  = (jump || take) ? exp_target : pc4;
    endtask

    function automatic logic [31:0] random_instr();
        rvx_instr_u  w;
        logic [31:0] r;
        logic [20:0] off;
        r   = $random(seed);
        w   = $random(seed);
        off = {{14{r[31]}}, r[30:26], 2'b00};  // small word-aligned offset
        w.r.rd  = {2'b00, r[2:0]};
        w.r.rs1 = {2'b00, r[5:3]};
        w.r.rs2 = {2'b00, r[8:6]};
        case (r[12:9])
            4'd0, 4'd1, 4'd2, 4'd15: begin
                w.r.opcode = `OPC_OP;
                w.r.funct7 = {1'b0, r[13] && (w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5), 5'd0};
                if (r[12:9] == 4'd15)
                    w.r.rs2 = 5'd0;
            end
            4'd3, 4'd4, 4'd5, 4'd14: begin
                w.i.opcode = `OPC_OP_IMM;
                if (w.i.funct3 == 3'd1 || w.i.funct3 == 3'd5)
                    w.i.imm[11:6] = {1'b0, r[13] && w.i.funct3 == 3'd5, 4'd0}; // shamt
                if (r[12:9] == 4'd14)
                    w.i.rs1 = 5'd0;
            end
            4'd6: w.u.opcode = `OPC_LUI;
            4'd7: w.u.opcode = `OPC_AUIPC;
            4'd8: begin
                w.j.opcode   = `OPC_JAL;
                w.j.imm20    = off[20];
                w.j.imm19_12 = off[19:12];
                w.j.imm11    = off[11];
                w.j.imm10_1  = off[10:1];
            end
            4'd9: begin
                w.i.opcode = `OPC_JALR;
                w.i.funct3 = 3'd0;
            end
            4'd10, 4'd11, 4'd12: begin
                w.b.opcode  = `OPC_BRANCH;
                w.b.funct3  = r[15:13] ^ ((r[15:13] == 3'd2 || r[15:13] == 3'd3) ? 3'd4 : 3'd0);
                w.b.imm12   = off[12];
                w.b.imm11   = off[11];
                w.b.imm10_5 = off[10:5];
                w.b.imm4_1  = off[4:1];
            end
            default: begin
                case (r[14:13])
                    2'd0:    w.r.opcode = 7'b0000011; // load
                    2'd1:    w.r.opcode = 7'b0100011; // store
                    2'd2:    w.r.opcode = 7'b1110011; // system
                    default: w.r.opcode = 7'b0111011; // op-32
                endcase
            end
        endcase
        return w;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // handshakes are settled mid-cycle
    always @(negedge clk) begin
        ev_accept   = !reset_i && in_valid_i && in_ready_o;
        ev_fire     = !reset_i && res_valid_o && res_ready_i;
        ev_redir    = !reset_i && redir_valid_o;
        ev_redir_pc = redir_pc_o;
        ev_instr    = in_instr_i;
        if (!reset_i && res_valid_o && !res_ready_i)
            n_stall++;
    end

    always @(posedge clk) begin
        if (reset_i) begin
            instr_q.delete();
            for (int k = 0; k < 32; k++)
                mregs[k] = '0;
            model_pc = `RESET_PC;
        end else begin
            drop = ev_fire && exp_redir;
            if (ev_fire && instr_q.size() != 0) begin
                if (exp_we)
                    mregs[instr_q[0][11:7]] = exp_value;
                n_redir   += int'(exp_redir);
                n_illegal += int'(exp_illegal);
                n_x0      += int'(exp_x0);
                model_pc   = exp_next;
                n_results++;
                void'(instr_q.pop_front());
            end
            if (ev_accept && !drop)
                instr_q.push_back(ev_instr);
        end
        exp_valid = instr_q.size() != 0;
        if (exp_valid)
            predict(instr_q[0]);
    end

    a_valid: assert property (@(negedge clk) disable iff (reset_i) res_valid_o == exp_valid)
        else begin
            err_value++;
            $display("[ERROR] %0t res_valid_o is %b, expected %b", $time, res_valid_o, exp_valid);
        end
    a_pc: assert property (@(negedge clk) disable iff (reset_i)
                           res_valid_o |-> res_pc_o == model_pc)
        else begin
            err_value++;
            $display("[ERROR] %0t result pc %h, expected %h", $time, res_pc_o, model_pc);
        end
    a_value: assert property (@(negedge clk) disable iff (reset_i)
                              res_valid_o && exp_we |-> res_value_o == exp_value
                                                        && res_rd_o == exp_rd)
        else begin
            err_value++;
            $display("[ERROR] %0t result x%0d = %h, expected x%0d = %h", $time, res_rd_o,
                     res_value_o, exp_rd, exp_value);
        end
    a_flags: assert property (@(negedge clk) disable iff (reset_i)
                              res_valid_o |-> res_we_o == exp_we && res_illegal_o == exp_illegal)
        else begin
            err_value++;
            $display("[ERROR] %0t we/illegal %b%b, expected %b%b", $time, res_we_o, res_illegal_o,
                     exp_we, exp_illegal);
        end
    a_redir: assert property (@(negedge clk) disable iff (reset_i)
                              redir_valid_o == (res_valid_o && res_ready_i && exp_redir))
        else begin
            err_value++;
            $display("[ERROR] %0t redir_valid_o is %b unexpectedly", $time, redir_valid_o);
        end
    a_redir_pc: assert property (@(negedge clk) disable iff (reset_i)
                                 redir_valid_o |-> redir_pc_o == exp_target)
        else begin
            err_value++;
            $display("[ERROR] %0t redirect pc %h, expected %h", $time, redir_pc_o, exp_target);
        end
    a_stall_ready: assert property (@(negedge clk) disable iff (reset_i)
                                    res_valid_o && !res_ready_i |-> !in_ready_o)
        else begin
            err_proto++;
            $display("in_ready_o was high while a result was stalled, at %0t", $time);
        end
    a_stall_hold: assert property (@(negedge clk) disable iff (reset_i)
        res_valid_o && !res_ready_i |=> res_valid_o
            && $stable({res_pc_o, res_rd_o, res_we_o, res_value_o, res_illegal_o}))
        else begin
            err_proto++;
            $display("result outputs changed while res_ready_i was low, at %0t", $time);
        end
    a_reset_state: assert property (@(negedge clk)
        $fell(reset_i) |-> in_ready_o && !res_valid_o && !redir_valid_o)
        else begin
            err_proto++;
            $display("handshake outputs not idle right after reset, at %0t", $time);
        end

    // instruction source that follows redirects
    initial begin
        gen_pc    = `RESET_PC;
        cur_instr = '0;
        need_new  = 1'b1;
        @(negedge reset_i);
        forever begin
            @(posedge clk);
            #2;
            if (ev_redir) begin
                gen_pc   = ev_redir_pc;
                need_new = 1'b1;
            end else if (ev_accept) begin
                gen_pc   = gen_pc + 64'd4;
                need_new = 1'b1;
            end
            if (need_new) begin
                cur_instr = random_instr();
                need_new  = 1'b0;
            end
            in_valid_i  = ($random(seed) & 3) != 0;
            in_pc_i     = gen_pc;
            in_instr_i  = cur_instr;
            res_ready_i = ($random(seed) & 3) != 0;
        end
    end

    initial begin
        seed        = 32;
        err_value   = 0;
        err_proto   = 0;
        err_cover   = 0;
        n_results   = 0;
        n_redir     = 0;
        n_illegal   = 0;
        n_x0        = 0;
        n_stall     = 0;
        reset_i     = 1'b1;
        in_valid_i  = 1'b0;
        in_pc_i     = '0;
        in_instr_i  = '0;
        res_ready_i = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        reset_i = 1'b0;
        wait (n_results >= NUM_INSTR);
        repeat (2) @(posedge clk);
        if (n_redir == 0 || n_illegal == 0 || n_x0 == 0 || n_stall == 0) begin
            err_cover++;
            $display("stimulus missed a case: redirects %0d, illegal %0d, x0 writes %0d, stalls %0d",
                     n_redir, n_illegal, n_x0, n_stall);
        end
        $display("results %0d, value errors %0d, protocol errors %0d, coverage gaps %0d",
                 n_results, err_value, err_proto, err_cover);
        if (err_value + err_proto + err_cover == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns with %0d of %0d results consumed",
                 TIMEOUT_NS, n_results, NUM_INSTR);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
hdl/rvx_pkg.sv
hdl/id_ex_if.sv
hdl/rvx_decoder.sv
hdl/rvx_regfile.sv
hdl/rvx_id_ex.sv
hdl/rvx_execute.sv
hdl/rvx_core_slice.sv
bench/tb_rvx_slice.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_rvx_slice -o tb_rvx_slice

./obj_dir/tb_rvx_slice | tee sim.log

if grep -qx '>>> PASS' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
